// ==== logic/qos_arb_top.sv ====
// qos arbiter top level with score unit and grant feedback
`timescale 1ns/100ps

module qos_arb_top
    import qos_pkg::*;
#(
    // longest wait counted into a score
    parameter int AGE_LIMIT = 7
) (
    input  logic               clk,
    input  logic               rst_n,
    // base priority write
    input  cfg_wr_t            cfg_i,
    // request levels, sampled every clock
    input  logic [NUM_REQ-1:0] req_i,
    // one-hot grant, three cycles behind the sample
    output logic [NUM_REQ-1:0] grant_o,
    // score that won, aligned with grant_o
    output logic [SCORE_W-1:0] grant_score_o
);

    // current per-requester scores
    score_vec_t scores;

    // grant_o loops back so a granted requester stops aging
    qos_score_unit #(
        .AGE_LIMIT (AGE_LIMIT)
    ) u_score (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_i    (cfg_i),
        .req_i    (req_i),
        .grant_i  (grant_o),
        .scores_o (scores)
    );

    qos_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (req_i),
        .scores_i      (scores),
        .grant_o       (grant_o),
        .grant_score_o (grant_score_o)
    );

endmodule

// ==== logic/qos_arbiter.sv ====
// three-stage max-score arbiter with lowest-index tie break
`timescale 1ns/100ps

module qos_arbiter
    import qos_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [NUM_REQ-1:0] req_i,
    input  score_vec_t         scores_i,
    output logic [NUM_REQ-1:0] grant_o,
    output logic [SCORE_W-1:0] grant_score_o
);

    // scores unpacked for indexing
    logic [SCORE_W-1:0] score [NUM_REQ];

    // beats[k][j] is set when requester k is not displaced by j
    logic [NUM_REQ-1:0] beats [NUM_REQ];

    // exactly one bit set when any request is present
    logic [NUM_REQ-1:0] win;

    // stage 1 input record
    arb_stage_t s1_d;

    // pipeline registers
    arb_stage_t s1_q;
    arb_stage_t s2_q;

    // one-hot grant decoded from stage 2
    logic [NUM_REQ-1:0] grant_d;

    assign score[0] = scores_i.score0;
    assign score[1] = scores_i.score1;
    assign score[2] = scores_i.score2;
    assign score[3] = scores_i.score3;

    // pairwise comparison
    // a lower index must be strictly beaten, a higher one only matched
    always_comb begin
        for (int k = 0; k < NUM_REQ; k++) begin
            for (int j = 0; j < NUM_REQ; j++) begin
                if (j == k || !req_i[j]) begin
                    beats[k][j] = 1'b1;
                end else if (j < k) begin
                    beats[k][j] = score[k] > score[j];
                end else begin
                    beats[k][j] = score[k] >= score[j];
                end
            end
        end
    end

    // winner must request and hold against every other requester
    always_comb begin
        for (int k = 0; k < NUM_REQ; k++) begin
            win[k] = req_i[k] && (&beats[k]);
        end
    end

    // encode the one-hot winner into a stage record
    always_comb begin
        s1_d       = ARB_STAGE_IDLE;
        s1_d.valid = |req_i;
        for (int k = 0; k < NUM_REQ; k++) begin
            if (win[k]) begin
                s1_d.idx   = IDX_W'(k);
                s1_d.score = score[k];
            end
        end
    end

    // stage 1, search result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_q <= ARB_STAGE_IDLE;
        end else begin
            s1_q <= s1_d;
        end
    end

    // stage 2, carry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_q <= ARB_STAGE_IDLE;
        end else begin
            s2_q <= s1_q;
        end
    end

    // index to one-hot, empty when no request was seen
    always_comb begin
        grant_d = '0;
        if (s2_q.valid) begin
            grant_d[s2_q.idx] = 1'b1;
        end
    end

    // stage 3, grant and its score
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_o       <= '0;
            grant_score_o <= '0;
        end else begin
            grant_o <= grant_d;
            if (s2_q.valid) begin
                grant_score_o <= s2_q.score;
            end else begin
                grant_score_o <= '0;
            end
        end
    end

endmodule

// ==== logic/qos_pkg.sv ====
// requester constants and packed structs for the qos arbiter
package qos_pkg;

    // requester count, fixed at four
    // the stage 1 comparison matrix is sized from this
    localparam int NUM_REQ = 4;

    // base priority and score share one width
    localparam int SCORE_W = 4;

    // index of one requester
    localparam int IDX_W = 2;

    // one score per requester
    // score0 sits in the low bits
    typedef struct packed {
        logic [SCORE_W-1:0] score3;
        logic [SCORE_W-1:0] score2;
        logic [SCORE_W-1:0] score1;
        logic [SCORE_W-1:0] score0;
    } score_vec_t;

    // configuration write into the score unit
    // a single-cycle strobe that loads one base priority
    typedef struct packed {
        // write strobe
        logic               wr;
        // requester to update
        logic [IDX_W-1:0]   idx;
        // new base priority
        logic [SCORE_W-1:0] base;
    } cfg_wr_t;

    // record passed between arbiter stages
    typedef struct packed {
        // at least one request was present
        logic               valid;
        // index of the winner
        logic [IDX_W-1:0]   idx;
        // score of the winner
        logic [SCORE_W-1:0] score;
    } arb_stage_t;

    // empty stage record, used at reset
    localparam arb_stage_t ARB_STAGE_IDLE = '{
        valid: 1'b0,
        idx:   '0,
        score: '0
    };

endpackage

// ==== logic/qos_score_unit.sv ====
// base priority registers, age counters and saturating scores
`timescale 1ns/100ps

module qos_score_unit
    import qos_pkg::*;
#(
    parameter int AGE_LIMIT = 7
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cfg_wr_t            cfg_i,
    input  logic [NUM_REQ-1:0] req_i,
    input  logic [NUM_REQ-1:0] grant_i,
    output score_vec_t         scores_o
);

    // ceiling for the age counters
    localparam logic [SCORE_W-1:0] AGE_MAX = SCORE_W'(AGE_LIMIT);

    // programmable base priorities
    logic [SCORE_W-1:0] base_q [NUM_REQ];

    // cycles spent waiting without a grant
    logic [SCORE_W-1:0] age_q [NUM_REQ];

    // base plus age with a carry bit
    logic [SCORE_W:0] sum_wide [NUM_REQ];

    // saturated scores
    logic [SCORE_W-1:0] score [NUM_REQ];

    // base priority writes, one requester per strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_REQ; k++) begin
                base_q[k] <= '0;
            end
        end else if (cfg_i.wr) begin
            base_q[cfg_i.idx] <= cfg_i.base;
        end
    end

    // aging
    // a requester ages only while it asks and is not granted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_REQ; k++) begin
                age_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_REQ; k++) begin
                if (!req_i[k] || grant_i[k]) begin
                    age_q[k] <= '0;
                end else if (age_q[k] != AGE_MAX) begin
                    age_q[k] <= age_q[k] + 1'b1;
                end
            end
        end
    end

    // score is base plus age, clamped to all ones on overflow
    always_comb begin
        for (int k = 0; k < NUM_REQ; k++) begin
            sum_wide[k] = {1'b0, base_q[k]} + {1'b0, age_q[k]};
            if (sum_wide[k][SCORE_W]) begin
                score[k] = '1;
            end else begin
                score[k] = sum_wide[k][SCORE_W-1:0];
            end
        end
    end

    // pack for the arbiter
    assign scores_o.score0 = score[0];
    assign scores_o.score1 = score[1];
    assign scores_o.score2 = score[2];
    assign scores_o.score3 = score[3];

endmodule

// ==== qos_arb.f ====
logic/qos_pkg.sv
logic/qos_score_unit.sv
logic/qos_arbiter.sv
logic/qos_arb_top.sv
sim/qos_arb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the qos arbiter testbench with Verilator.
# Exits non-zero unless the testbench reports success.

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal \
    -f qos_arb.f \
    --top-module qos_arb_tb \
    --Mdir obj_dir \
    -o qos_arb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/qos_arb_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" <<< "$output"; then
    exit 0
fi

echo "simulation did not report success"
exit 1

// ==== sim/qos_arb_tb.sv ====
// testbench for qos_arb_top with a stimulus table, reference model, lfsr and watchdog
`timescale 1ns/100ps

module qos_arb_tb
    import qos_pkg::*;
;

    localparam int AGE_LIMIT = 7;
    localparam int NUM_ROWS  = 8;
    localparam int RESET_CYC = 16;
    localparam int DRAIN     = 4;
    localparam int MARGIN    = 50;

    localparam logic [1:0] MODE_STEADY = 2'd0;
    localparam logic [1:0] MODE_ROTATE = 2'd1;
    localparam logic [1:0] MODE_RANDOM = 2'd2;

    // one stimulus row, base k sits in bases[4k+3:4k]
    typedef struct packed {
        logic [15:0]        bases;
        logic [NUM_REQ-1:0] req;
        logic [15:0]        hold;
        logic [1:0]         mode;
        logic               chk;
        logic [NUM_REQ-1:0] exp_grant;
        logic [SCORE_W-1:0] exp_score;
        logic [3:0]         lat;
    } row_t;

    logic               clk;
    logic               rst_n;
    cfg_wr_t            cfg;
    logic [NUM_REQ-1:0] req;
    logic [NUM_REQ-1:0] grant_o;
    logic [SCORE_W-1:0] grant_score_o;

    row_t  rows [NUM_ROWS];
    string names [NUM_ROWS];

    // reference model state
    logic [SCORE_W-1:0] m_base [NUM_REQ];
    int                 m_age [NUM_REQ];
    arb_stage_t         m_s1;
    arb_stage_t         m_s2;
    logic [NUM_REQ-1:0] m_grant;
    logic [SCORE_W-1:0] m_gscore;

    logic [31:0] lfsr;
    int          errors;
    int          pass_count;
    int          fail_count;
    int          cycles;
    int          limit;

    qos_arb_top #(
        .AGE_LIMIT (AGE_LIMIT)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_i         (cfg),
        .req_i         (req),
        .grant_o       (grant_o),
        .grant_score_o (grant_score_o)
    );

    always #10 clk = ~clk;

    // watchdog over the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // advance the model across one rising edge, using the inputs held before it
    task automatic model_step();
        int                 sum;
        logic [SCORE_W-1:0] sc [NUM_REQ];
        arb_stage_t         best;
        logic [NUM_REQ-1:0] g_next;
        logic [SCORE_W-1:0] gs_next;
        for (int k = 0; k < NUM_REQ; k++) begin
            sum   = int'(m_base[k]) + m_age[k];
            sc[k] = (sum > 15) ? 4'hf : SCORE_W'(sum);
        end
        // running best, replaced only by a strictly greater score
        best = '0;
        for (int k = 0; k < NUM_REQ; k++) begin
            if (req[k] && (!best.valid || sc[k] > best.score)) begin
                best.valid = 1'b1;
                best.idx   = IDX_W'(k);
                best.score = sc[k];
            end
        end
        g_next  = '0;
        gs_next = '0;
        if (m_s2.valid) begin
            g_next  = NUM_REQ'(1) << m_s2.idx;
            gs_next = m_s2.score;
        end
        for (int k = 0; k < NUM_REQ; k++) begin
            if (!req[k] || m_grant[k]) begin
                m_age[k] = 0;
            end else if (m_age[k] < AGE_LIMIT) begin
                m_age[k] = m_age[k] + 1;
            end
        end
        if (cfg.wr) begin
            m_base[cfg.idx] = cfg.base;
        end
        m_grant  = g_next;
        m_gscore = gs_next;
        m_s2     = m_s1;
        m_s1     = best;
    endtask

    // one clock, then compare outputs with the model at the falling edge
    task automatic tick();
        @(negedge clk);
        model_step();
        if (grant_o !== m_grant) begin
            $display("ERROR t=%0t grant_o expected %b got %b", $time, m_grant, grant_o);
            errors++;
        end
        if (grant_score_o !== m_gscore) begin
            $display("ERROR t=%0t grant_score_o expected %0d got %0d",
                     $time, m_gscore, grant_score_o);
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        row_t               row;
        logic [31:0]        rnd;
        logic [NUM_REQ-1:0] pat;
        int                 first_c;
        int                 err_start;
        int                 s;
        row       = rows[r];
        err_start = errors;
        first_c   = -1;
        req       = '0;
        repeat (DRAIN) tick();
        // load the four base priorities
        for (int k = 0; k < NUM_REQ; k++) begin
            cfg.wr   = 1'b1;
            cfg.idx  = IDX_W'(k);
            cfg.base = row.bases[4*k +: 4];
            if (row.mode == MODE_RANDOM) begin
                draw_bits(SCORE_W, rnd);
                cfg.base = rnd[SCORE_W-1:0];
            end
            tick();
        end
        cfg = '0;
        for (int c = 0; c < int'(row.hold); c++) begin
            s = c % NUM_REQ;
            case (row.mode)
                MODE_ROTATE: pat = (row.req << s) | (row.req >> (NUM_REQ - s));
                MODE_RANDOM: begin
                    draw_bits(NUM_REQ, rnd);
                    pat = rnd[NUM_REQ-1:0];
                end
                default:     pat = row.req;
            endcase
            req = pat;
            tick();
            // latency in rising edges, the sampling edge counts as the first
            if (first_c < 0 && grant_o != '0) begin
                first_c = c + 1;
            end
        end
        if (row.chk && grant_o !== row.exp_grant) begin
            $display("ERROR t=%0t grant_o expected %b got %b", $time, row.exp_grant, grant_o);
            errors++;
        end
        if (row.chk && grant_score_o !== row.exp_score) begin
            $display("ERROR t=%0t grant_score_o expected %0d got %0d",
                     $time, row.exp_score, grant_score_o);
            errors++;
        end
        if (row.lat != 0 && first_c != int'(row.lat)) begin
            $display("ERROR t=%0t grant latency expected %0d got %0d", $time, row.lat, first_c);
            errors++;
        end
        if (errors == err_start) begin
            pass_count++;
            $display("test %0d %s: ok", r, names[r]);
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", r, names[r], errors - err_start);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = '0;
        cfg        = '0;
        lfsr       = 32'h275e_0c16;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        cycles     = 0;
        m_s1       = '0;
        m_s2       = '0;
        m_grant    = '0;
        m_gscore   = '0;
        for (int k = 0; k < NUM_REQ; k++) begin
            m_base[k] = '0;
            m_age[k]  = 0;
        end

        // bases, req, hold, mode, end check, grant, score, latency
        rows[0] = '{16'h0000, 4'b0000, 16'd6, MODE_STEADY, 1'b1, 4'b0000, 4'd0, 4'd0};
        rows[1] = '{16'h0500, 4'b0100, 16'd3, MODE_STEADY, 1'b1, 4'b0100, 4'd5, 4'd3};
        rows[2] = '{16'h2693, 4'b1111, 16'd3, MODE_STEADY, 1'b1, 4'b0010, 4'd9, 4'd3};
        rows[3] = '{16'h7777, 4'b1110, 16'd3, MODE_STEADY, 1'b1, 4'b0010, 4'd7, 4'd3};
        // requester 0 overtakes requester 1 after aging
        rows[4] = '{16'h0095, 4'b0011, 16'd8, MODE_STEADY, 1'b1, 4'b0001, 4'd10, 4'd3};
        // both saturate at 15, tie goes to index 0
        rows[5] = '{16'hf00d, 4'b1001, 16'd5, MODE_STEADY, 1'b1, 4'b0001, 4'd15, 4'd3};
        rows[6] = '{16'h7654, 4'b0001, 16'd7, MODE_ROTATE, 1'b1, 4'b0001, 4'd4, 4'd3};
        rows[7] = '{16'h0000, 4'b0000, 16'd200, MODE_RANDOM, 1'b0, 4'b0000, 4'd0, 4'd0};
        names[0] = "idle";
        names[1] = "single requester";
        names[2] = "highest base";
        names[3] = "equal bases";
        names[4] = "aging";
        names[5] = "saturation";
        names[6] = "pipelined sequence";
        names[7] = "random";

        limit = RESET_CYC + DRAIN + MARGIN;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + DRAIN + NUM_REQ + int'(rows[r].hold);
        end

        repeat (RESET_CYC) @(negedge clk);
        if (grant_o !== '0 || grant_score_o !== '0) begin
            $display("grant outputs were not zero while reset was held");
            errors++;
        end
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        req = '0;
        repeat (DRAIN) tick();

        $display("tests passed %0d, failed %0d, value errors %0d", pass_count, fail_count,
                 errors);
        if (fail_count == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
